//--- src/jedro_isa_pkg.sv
//////////////////////////////////////////////////////////////////////
// jedro isa package
// rv32i instruction encoding for the integer execute slice:
// opcodes, funct3/funct7 values and instruction field positions
//////////////////////////////////////////////////////////////////////

package jedro_isa_pkg;

  localparam int INSTR_WIDTH  = 32;
  localparam int OPCODE_WIDTH = 7;

  typedef logic [INSTR_WIDTH-1:0]  instr_t;   // raw instruction word
  typedef logic [OPCODE_WIDTH-1:0] opcode_t;
  typedef logic [2:0]              funct3_t;
  typedef logic [6:0]              funct7_t;

  // field positions (lsb of each field)
  localparam int RD_LSB    = 7;
  localparam int F3_LSB    = 12;
  localparam int RS1_LSB   = 15;
  localparam int RS2_LSB   = 20;
  localparam int F7_LSB    = 25;
  localparam int IMM_I_LSB = 20;  // i-type imm is [31:20]
  localparam int IMM_U_LSB = 12;  // u-type imm is [31:12]

  // major opcodes
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;

  // funct3 values, shared by OP and OP-IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SR      = 3'b101;  // srl / sra
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;  // bit 30, sub / sra

endpackage

//--- src/jedro_core_pkg.sv
//////////////////////////////////////////////////////////////////////
// jedro core package
// datapath widths, vector types and the alu operation encoding
//////////////////////////////////////////////////////////////////////

package jedro_core_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int SHAMT_WIDTH    = 5;
  localparam int ALU_OP_WIDTH   = 4;
  localparam int NUM_REGS       = 2**REG_ADDR_WIDTH;  // incl. x0

  typedef logic [DATA_WIDTH-1:0]     data_t;      // one register value
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;  // register index
  typedef logic [SHAMT_WIDTH-1:0]    shamt_t;     // shift amount

  // alu operations
  // low three bits follow funct3, bit 3 is the alternate (bit 30) flag
  typedef enum logic [ALU_OP_WIDTH-1:0] {
    ALU_OP_ADD  = 4'b0000,
    ALU_OP_SLL  = 4'b0001,
    ALU_OP_SLT  = 4'b0010,
    ALU_OP_SLTU = 4'b0011,
    ALU_OP_XOR  = 4'b0100,
    ALU_OP_SRL  = 4'b0101,
    ALU_OP_OR   = 4'b0110,
    ALU_OP_AND  = 4'b0111,
    ALU_OP_SUB  = 4'b1000,
    ALU_OP_SRA  = 4'b1101
  } alu_op_t;

endpackage

//--- src/jedro_decoder.sv
//////////////////////////////////////////////////////////////////////
// jedro decoder
// splits the instruction, forms immediates, picks operands (with
// bypass from the alu output) and selects the alu operation.
// flags anything outside OP / OP-IMM / LUI as illegal
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module jedro_decoder
  import jedro_core_pkg::*;
  import jedro_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      instr_valid_i,
  input  instr_t    instr_i,
  // register file read ports
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  input  data_t     rs1_data_i,
  input  data_t     rs2_data_i,
  // bypass from alu output stage
  input  data_t     byp_data_i,
  input  reg_addr_t byp_addr_i,
  input  logic      byp_wb_i,
  // to alu
  output alu_op_t   alu_sel_o,
  output data_t     op_a_o,
  output data_t     op_b_o,
  output reg_addr_t dest_addr_o,
  output logic      wb_o,
  output logic      illegal_o
);

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  logic    alt;        // funct7 == alt pattern
  data_t   imm_itype;
  data_t   imm_utype;
  data_t   imm;        // immediate chosen for op_b
  data_t   rs1_val;
  data_t   rs2_val;
  logic    byp_rs1;
  logic    byp_rs2;
  logic    legal;
  logic    use_imm;
  logic    zero_a;     // lui, op_a forced to 0

  //////////////////////////////////////////////////////////////////////
  // field extraction
  //////////////////////////////////////////////////////////////////////
  assign opcode      = instr_i[OPCODE_WIDTH-1:0];
  assign dest_addr_o = instr_i[RD_LSB +: REG_ADDR_WIDTH];
  assign funct3      = instr_i[F3_LSB +: $bits(funct3_t)];
  assign rs1_addr_o  = instr_i[RS1_LSB +: REG_ADDR_WIDTH];
  assign rs2_addr_o  = instr_i[RS2_LSB +: REG_ADDR_WIDTH];
  assign funct7      = instr_i[F7_LSB +: $bits(funct7_t)];
  assign alt         = (funct7 == F7_ALT);

  // sign extended i-type, zero filled u-type
  assign imm_itype = {{IMM_I_LSB{instr_i[INSTR_WIDTH-1]}}, instr_i[INSTR_WIDTH-1:IMM_I_LSB]};
  assign imm_utype = {instr_i[INSTR_WIDTH-1:IMM_U_LSB], {IMM_U_LSB{1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // opcode classification and alu select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    legal     = 1'b0;
    use_imm   = 1'b0;
    zero_a    = 1'b0;
    imm       = imm_itype;
    alu_sel_o = alu_op_t'({1'b0, funct3});
    case (opcode)
      OPC_OP: begin
        alu_sel_o = alu_op_t'({alt, funct3});
        // alt only for sub and sra
        legal = (funct7 == F7_BASE) || (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          F3_SLL: legal = (funct7 == F7_BASE);
          F3_SR: begin
            legal     = (funct7 == F7_BASE) || alt;
            alu_sel_o = alu_op_t'({alt, funct3});  // srai
          end
          default: legal = 1'b1;  // upper bits are plain immediate
        endcase
      end
      OPC_LUI: begin
        legal     = 1'b1;
        use_imm   = 1'b1;
        zero_a    = 1'b1;
        imm       = imm_utype;
        alu_sel_o = ALU_OP_ADD;  // 0 + upper imm
      end
      default: legal = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // operand selection
  //////////////////////////////////////////////////////////////////////
  // previous instruction not yet in the regfile, take it from the alu
  assign byp_rs1 = byp_wb_i && (byp_addr_i == rs1_addr_o) && (rs1_addr_o != '0);
  assign byp_rs2 = byp_wb_i && (byp_addr_i == rs2_addr_o) && (rs2_addr_o != '0);
  assign rs1_val = byp_rs1 ? byp_data_i : rs1_data_i;
  assign rs2_val = byp_rs2 ? byp_data_i : rs2_data_i;

  assign op_a_o = zero_a  ? '0  : rs1_val;
  assign op_b_o = use_imm ? imm : rs2_val;

  assign wb_o      = instr_valid_i &  legal;
  assign illegal_o = instr_valid_i & ~legal;

endmodule

//--- src/jedro_regfile.sv
//////////////////////////////////////////////////////////////////////
// jedro register file
// 32 x 32 bit, two async read ports, one sync write port.
// x0 reads as zero and drops writes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module jedro_regfile
  import jedro_core_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  // read ports
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  output data_t     rs1_data_o,
  output data_t     rs2_data_o,
  // write port
  input  logic      we_i,
  input  reg_addr_t wr_addr_i,
  input  data_t     wr_data_i
);

  // x0 has no storage
  data_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end
    else if (we_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // async reads, x0 hard wired
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- src/jedro_alu.sv
//////////////////////////////////////////////////////////////////////
// jedro alu
// rv32i integer alu with registered result. destination address,
// write enable and illegal flag are carried alongside the result
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module jedro_alu
  import jedro_core_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,

  input  alu_op_t   sel_i,        // alu operation
  input  data_t     op_a_i,
  input  data_t     op_b_i,
  output data_t     res_ro,

  input  reg_addr_t dest_addr_i,
  output reg_addr_t dest_addr_ro,

  input  logic      wb_i,
  output logic      wb_ro,

  input  logic      illegal_i,
  output logic      illegal_ro
);

  data_t  op_b_add;     // b, inverted for sub
  data_t  adder_res;
  data_t  and_res;
  data_t  or_res;
  data_t  xor_res;
  data_t  lt_sign_res;
  data_t  lt_unsign_res;
  data_t  shl_res;
  data_t  shr_res;
  data_t  res_mux;
  shamt_t shamt;
  logic   shr_fill;     // bit shifted in from the left
  logic [DATA_WIDTH:0] shr_ext;

  //////////////////////////////////////////////////////////////////////
  // arithmetic and logic
  //////////////////////////////////////////////////////////////////////
  // single adder, sub = a + ~b + 1
  assign op_b_add  = sel_i[ALU_OP_WIDTH-1] ? ~op_b_i : op_b_i;
  assign adder_res = op_a_i + op_b_add + data_t'(sel_i[ALU_OP_WIDTH-1]);

  assign and_res = op_a_i & op_b_i;
  assign or_res  = op_a_i | op_b_i;
  assign xor_res = op_a_i ^ op_b_i;

  // compares, result is 0 or 1
  assign lt_sign_res   = data_t'($signed(op_a_i) < $signed(op_b_i));
  assign lt_unsign_res = data_t'(op_a_i < op_b_i);

  // shifts use low five bits of b only
  assign shamt    = op_b_i[SHAMT_WIDTH-1:0];
  assign shl_res  = op_a_i << shamt;
  // one extra msb carries the fill bit, sel bit 3 picks sra
  assign shr_fill = sel_i[ALU_OP_WIDTH-1] & op_a_i[DATA_WIDTH-1];
  assign shr_ext  = $signed({shr_fill, op_a_i}) >>> shamt;
  assign shr_res  = shr_ext[DATA_WIDTH-1:0];

  //////////////////////////////////////////////////////////////////////
  // result mux
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (sel_i)
      ALU_OP_ADD,
      ALU_OP_SUB:  res_mux = adder_res;
      ALU_OP_SLL:  res_mux = shl_res;
      ALU_OP_SLT:  res_mux = lt_sign_res;
      ALU_OP_SLTU: res_mux = lt_unsign_res;
      ALU_OP_XOR:  res_mux = xor_res;
      ALU_OP_SRL,
      ALU_OP_SRA:  res_mux = shr_res;
      ALU_OP_OR:   res_mux = or_res;
      ALU_OP_AND:  res_mux = and_res;
      default:     res_mux = '0;
    endcase
  end

  // result register
  always_ff @(posedge clk_i) begin
    res_ro <= res_mux;
  end

  //////////////////////////////////////////////////////////////////////
  // go-through signals
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      dest_addr_ro <= '0;
      wb_ro        <= 1'b0;
      illegal_ro   <= 1'b0;
    end
    else begin
      dest_addr_ro <= dest_addr_i;
      wb_ro        <= wb_i;
      illegal_ro   <= illegal_i;
    end
  end

endmodule

//--- src/jedro_writeback.sv
//////////////////////////////////////////////////////////////////////
// jedro writeback
// drives the regfile write port and registers the retire report
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module jedro_writeback
  import jedro_core_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  // from alu
  input  data_t     res_i,
  input  reg_addr_t dest_addr_i,
  input  logic      wb_i,
  input  logic      illegal_i,
  // regfile write port
  output logic      rf_we_o,
  output reg_addr_t rf_addr_o,
  output data_t     rf_data_o,
  // retire report
  output logic      retire_valid_o,
  output reg_addr_t retire_rd_o,
  output data_t     retire_data_o,
  output logic      retire_illegal_o
);

  // x0 never written
  assign rf_we_o   = wb_i && (dest_addr_i != '0);
  assign rf_addr_o = dest_addr_i;
  assign rf_data_o = res_i;

  // retire strobes
  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      retire_valid_o   <= 1'b0;
      retire_illegal_o <= 1'b0;
    end
    else begin
      retire_valid_o   <= wb_i;       // x0 targets retire too
      retire_illegal_o <= illegal_i;
    end
  end

  // retire payload
  always_ff @(posedge clk_i) begin
    retire_rd_o   <= dest_addr_i;
    retire_data_o <= res_i;
  end

endmodule

//--- src/jedro_exec_top.sv
//////////////////////////////////////////////////////////////////////
// jedro execute slice top
// decoder, register file, alu and writeback for rv32i OP,
// OP-IMM and LUI. two cycle latency from instruction to retire
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module jedro_exec_top
  import jedro_core_pkg::*;
  import jedro_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      instr_valid_i,
  input  instr_t    instr_i,
  output logic      retire_valid_o,
  output reg_addr_t retire_rd_o,
  output data_t     retire_data_o,
  output logic      retire_illegal_o
);

  // decoder <-> regfile
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  data_t     rs1_data;
  data_t     rs2_data;
  // decoder -> alu
  alu_op_t   alu_sel;
  data_t     op_a;
  data_t     op_b;
  reg_addr_t dec_dest_addr;
  logic      dec_wb;
  logic      dec_illegal;
  // alu -> writeback, bypass
  data_t     alu_res;
  reg_addr_t alu_dest_addr;
  logic      alu_wb;
  logic      alu_illegal;
  // writeback -> regfile
  logic      rf_we;
  reg_addr_t rf_addr;
  data_t     rf_data;

  jedro_decoder decoder_inst (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .byp_data_i    (alu_res),
    .byp_addr_i    (alu_dest_addr),
    .byp_wb_i      (alu_wb),
    .alu_sel_o     (alu_sel),
    .op_a_o        (op_a),
    .op_b_o        (op_b),
    .dest_addr_o   (dec_dest_addr),
    .wb_o          (dec_wb),
    .illegal_o     (dec_illegal)
  );

  jedro_regfile regfile_inst (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .wr_addr_i  (rf_addr),
    .wr_data_i  (rf_data)
  );

  jedro_alu alu_inst (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .sel_i        (alu_sel),
    .op_a_i       (op_a),
    .op_b_i       (op_b),
    .res_ro       (alu_res),
    .dest_addr_i  (dec_dest_addr),
    .dest_addr_ro (alu_dest_addr),
    .wb_i         (dec_wb),
    .wb_ro        (alu_wb),
    .illegal_i    (dec_illegal),
    .illegal_ro   (alu_illegal)
  );

  jedro_writeback writeback_inst (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .res_i            (alu_res),
    .dest_addr_i      (alu_dest_addr),
    .wb_i             (alu_wb),
    .illegal_i        (alu_illegal),
    .rf_we_o          (rf_we),
    .rf_addr_o        (rf_addr),
    .rf_data_o        (rf_data),
    .retire_valid_o   (retire_valid_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_illegal_o (retire_illegal_o)
  );

endmodule

//--- tests/jedro_exec_asserts.sv
//////////////////////////////////////////////////////////////////////
// jedro execute slice assertions
// retire protocol and write port rules, bound into the top level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module jedro_exec_asserts
  import jedro_core_pkg::*;
(
  input logic      clk_i,
  input logic      rstn_i,
  input logic      instr_valid_i,
  input logic      retire_valid_i,
  input logic      retire_illegal_i,
  input logic      wb_i,
  input reg_addr_t dest_addr_i,
  input logic      rf_we_i
);

  int fail_cnt = 0;  // failed assertions so far

  // legal and illegal retire are exclusive
  a_retire_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(retire_valid_i && retire_illegal_i))
    else begin
      fail_cnt++;
      $error("retire valid and retire illegal are high in the same cycle");
    end

  // fixed two cycle latency, every instruction retires
  a_retire_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
    instr_valid_i |-> ##2 (retire_valid_i || retire_illegal_i))
    else begin
      fail_cnt++;
      $error("valid instruction did not retire two cycles later");
    end

  // no retire without an instruction behind it
  a_no_orphan: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (retire_valid_i || retire_illegal_i) |-> $past(instr_valid_i, 2))
    else begin
      fail_cnt++;
      $error("retire pulse without an instruction two cycles earlier");
    end

  // x0 target from the decoder, no write once it reaches writeback
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (wb_i && (dest_addr_i == '0)) |=> !rf_we_i)
    else begin
      fail_cnt++;
      $error("register file write enable is high for x0");
    end

endmodule

bind jedro_exec_top jedro_exec_asserts asserts_inst (
  .clk_i            (clk_i),
  .rstn_i           (rstn_i),
  .instr_valid_i    (instr_valid_i),
  .retire_valid_i   (retire_valid_o),
  .retire_illegal_i (retire_illegal_o),
  .wb_i             (dec_wb),
  .dest_addr_i      (dec_dest_addr),
  .rf_we_i          (rf_we)
);

//--- tests/jedro_exec_checker.sv
//////////////////////////////////////////////////////////////////////
// jedro execute slice checker
// rv32i reference model in program order, two stage expected queue
// compared against the retire ports
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module jedro_exec_checker
  import jedro_core_pkg::*;
  import jedro_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      instr_valid_i,
  input  instr_t    instr_i,
  input  logic      retire_valid_i,
  input  reg_addr_t retire_rd_i,
  input  data_t     retire_data_i,
  input  logic      retire_illegal_i,
  output int        err_cnt_o,
  output int        chk_cnt_o,
  output int        pending_o
);

  data_t     model [NUM_REGS];  // x0 entry stays zero
  logic      exp_valid [2];     // [0] issued last cycle, [1] due now
  logic      exp_legal [2];
  reg_addr_t exp_rd    [2];
  data_t     exp_data  [2];
  int        errs = 0;
  int        chks = 0;

  // shared OP / OP-IMM semantics, b is rs2 or the immediate
  function automatic data_t rv32_op(input funct3_t f3, input data_t a, input data_t b);
    case (f3)
      F3_ADD_SUB: return a + b;
      F3_SLL:     return a << b[4:0];
      F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
      F3_XOR:     return a ^ b;
      F3_SR:      return a >> b[4:0];  // logical
      F3_OR:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  task automatic execute_model(input instr_t w, output logic legal, output reg_addr_t rd,
                               output data_t val);
    funct3_t f3;
    funct7_t f7;
    data_t   a;
    data_t   b;
    data_t   imm;
    f3    = w[14:12];
    f7    = w[31:25];
    rd    = w[11:7];
    a     = model[w[19:15]];
    b     = model[w[24:20]];
    imm   = {{20{w[31]}}, w[31:20]};
    legal = 1'b1;
    val   = '0;
    case (w[6:0])
      OPC_LUI: val = {w[31:12], 12'h000};
      OPC_OP: begin
        if (f7 == F7_ALT && f3 == F3_ADD_SUB) val = a - b;
        else if (f7 == F7_ALT && f3 == F3_SR) val = $signed(a) >>> b[4:0];
        else if (f7 != F7_BASE) legal = 1'b0;
        else val = rv32_op(f3, a, b);
      end
      OPC_OP_IMM: begin
        if (f3 == F3_SR && f7 == F7_ALT) val = $signed(a) >>> w[24:20];  // srai
        else if ((f3 == F3_SLL || f3 == F3_SR) && f7 != F7_BASE) legal = 1'b0;
        else val = rv32_op(f3, a, imm);
      end
      default: legal = 1'b0;
    endcase
    if (legal && rd != '0) model[rd] = val;
  endtask

  task automatic check_field(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errs++;
    end
  endtask

  always @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      for (int i = 0; i < NUM_REGS; i++) model[i] = '0;
      exp_valid[0] = 1'b0;
      exp_valid[1] = 1'b0;
    end
    else begin
      check_field("retire_valid_o", data_t'(retire_valid_i), data_t'(exp_valid[1] & exp_legal[1]));
      check_field("retire_illegal_o", data_t'(retire_illegal_i),
                  data_t'(exp_valid[1] & ~exp_legal[1]));
      if (exp_valid[1] && exp_legal[1]) begin
        check_field("retire_rd_o", data_t'(retire_rd_i), data_t'(exp_rd[1]));
        check_field("retire_data_o", retire_data_i, exp_data[1]);
      end
      if (retire_valid_i || retire_illegal_i) chks++;  // dut retires of either kind
      exp_valid[1] = exp_valid[0];   // advance the queue
      exp_legal[1] = exp_legal[0];
      exp_rd[1]    = exp_rd[0];
      exp_data[1]  = exp_data[0];
      exp_valid[0] = instr_valid_i;
      if (instr_valid_i) execute_model(instr_i, exp_legal[0], exp_rd[0], exp_data[0]);
    end
    err_cnt_o <= errs;
    chk_cnt_o <= chks;
    pending_o <= int'(exp_valid[0]) + int'(exp_valid[1]);
  end

endmodule

//--- tests/jedro_exec_tb.sv
//////////////////////////////////////////////////////////////////////
// jedro execute slice testbench
// lfsr driven OP / OP-IMM / LUI / illegal streams, dependent chains
// and idle gaps, checked by the checker module
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module jedro_exec_tb
  import jedro_core_pkg::*;
  import jedro_isa_pkg::*;
();

  localparam int N_OP       = 300;
  localparam int N_IMM      = 300;
  localparam int N_CHAIN    = 200;
  localparam int N_X0       = 60;
  localparam int N_ILL      = 100;
  localparam int N_IDLE     = 150;
  localparam int N_TOTAL    = N_OP + N_IMM + N_CHAIN + N_X0 + N_ILL + N_IDLE;
  localparam int MAX_CYCLES = 2 * N_TOTAL + 50;

  logic        clk_i;
  logic        rstn_i;
  logic        instr_valid_i;
  instr_t      instr_i;
  logic        retire_valid_o;
  reg_addr_t   retire_rd_o;
  data_t       retire_data_o;
  logic        retire_illegal_o;
  int          err_cnt;
  int          chk_cnt;
  int          pending;    // instructions still in flight
  logic [31:0] lfsr_state;
  int          err_mark;
  int          tests_failed;
  int          total_err;
  int          cycles;

  jedro_exec_top i_dut (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .retire_valid_o   (retire_valid_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_illegal_o (retire_illegal_o)
  );

  jedro_exec_checker i_checker (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .retire_valid_i   (retire_valid_o),
    .retire_rd_i      (retire_rd_o),
    .retire_data_i    (retire_data_o),
    .retire_illegal_i (retire_illegal_o),
    .err_cnt_o        (err_cnt),
    .chk_cnt_o        (chk_cnt),
    .pending_o        (pending)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // random source and instruction builders
  //////////////////////////////////////////////////////////////////////
  // right shifting galois form, taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'hA300_0000;
    else return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic reg_addr_t any_reg();
    return reg_addr_t'(take_bits(REG_ADDR_WIDTH));
  endfunction

  function automatic reg_addr_t nonzero_reg();
    reg_addr_t r;
    r = any_reg();
    if (r == '0) r = reg_addr_t'(NUM_REGS - 1);
    return r;
  endfunction

  function automatic reg_addr_t chain_reg();  // x1..x3
    reg_addr_t r;
    r = reg_addr_t'(take_bits(2));
    if (r == '0) r = reg_addr_t'(2);
    return r;
  endfunction

  function automatic instr_t gen_op(input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
    funct3_t f3;
    funct7_t f7;
    f3 = funct3_t'(take_bits(3));
    f7 = F7_BASE;
    if ((f3 == F3_ADD_SUB || f3 == F3_SR) && take_bits(1) == 1) f7 = F7_ALT;  // sub / sra
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic instr_t gen_imm(input reg_addr_t rd, input reg_addr_t rs1);
    funct3_t     f3;
    logic [11:0] imm;
    f3  = funct3_t'(take_bits(3));
    imm = take_bits(12);
    if (f3 == F3_SLL) imm[11:5] = F7_BASE;
    if (f3 == F3_SR) begin
      imm[11:5] = F7_BASE;
      if (take_bits(1) == 1) imm[11:5] = F7_ALT;  // srai
    end
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  // OP-IMM or LUI, even odds
  function automatic instr_t gen_imm_lui(input reg_addr_t rd, input reg_addr_t rs1);
    logic [19:0] upper;
    upper = take_bits(20);
    if (take_bits(1) == 1) return {upper, rd, OPC_LUI};
    else return gen_imm(rd, rs1);
  endfunction

  function automatic instr_t gen_legal(input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2);
    logic [1:0]  kind;
    logic [19:0] upper;
    kind  = take_bits(2);
    upper = take_bits(20);
    if (kind == 2'd3) return {upper, rd, OPC_LUI};
    else if (kind == 2'd2) return gen_imm(rd, rs1);
    else return gen_op(rd, rs1, rs2);
  endfunction

  // bad opcode, or OP / shift-imm with a funct7 that is neither base nor alt
  function automatic instr_t gen_illegal();
    instr_t  w;
    opcode_t opc;
    funct7_t f7;
    w   = take_bits(32);
    opc = take_bits(7);
    f7  = take_bits(7);
    if (f7 == F7_BASE || f7 == F7_ALT) f7[0] = 1'b1;
    if (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI) opc[0] = ~opc[0];
    case (take_bits(2))
      2'd2: w = {f7, w[24:12], w[11:7], OPC_OP};
      2'd3: w = {f7, w[24:15], (w[12] ? F3_SR : F3_SLL), w[11:7], OPC_OP_IMM};
      default: w[6:0] = opc;
    endcase
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // drive and sequencing
  //////////////////////////////////////////////////////////////////////
  task automatic send(input instr_t w);
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    instr_i       <= w;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      instr_valid_i <= 1'b0;
      instr_i       <= take_bits(32);  // junk while not valid
    end
  endtask

  function automatic int errors_so_far();
    return err_cnt + i_dut.asserts_inst.fail_cnt;
  endfunction

  // drain the pipeline, then report this test
  task automatic finish_test(input string name, input int n_instr);
    int errs;
    idle(2);
    while (pending != 0) idle(1);
    errs = errors_so_far() - err_mark;
    err_mark = errors_so_far();
    if (errs != 0) tests_failed++;
    $display("test %-10s %4d instructions, %0d errors", name, n_instr, errs);
  endtask

  initial begin
    rstn_i        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    lfsr_state    = 32'heee5;
    err_mark      = 0;
    tests_failed  = 0;
    repeat (2) @(posedge clk_i);
    rstn_i <= 1'b1;

    // immediates first so the registers hold nonzero values
    for (int i = 0; i < N_IMM; i++) send(gen_imm_lui(nonzero_reg(), any_reg()));
    finish_test("op_imm_lui", N_IMM);
    for (int i = 0; i < N_OP; i++) send(gen_op(reg_addr_t'(1 + (i * 7) % 31), any_reg(), any_reg()));
    finish_test("op_reg", N_OP);
    for (int i = 0; i < N_CHAIN; i++) send(gen_legal(chain_reg(), chain_reg(), chain_reg()));
    finish_test("chain", N_CHAIN);
    for (int i = 0; i < N_X0; i++) begin
      if (i % 2 == 0) send(gen_legal('0, any_reg(), any_reg()));  // write x0
      else send(gen_op(nonzero_reg(), '0, any_reg()));             // read x0
    end
    finish_test("x0", N_X0);
    for (int i = 0; i < N_ILL; i++) send(gen_illegal());
    finish_test("illegal", N_ILL);
    for (int i = 0; i < N_IDLE; i++) begin
      send(gen_legal(nonzero_reg(), any_reg(), any_reg()));
      idle(take_bits(2));
    end
    finish_test("idle_gaps", N_IDLE);

    total_err = errors_so_far();
    if (chk_cnt != N_TOTAL) begin
      $display("retired %0d instructions but %0d were issued", chk_cnt, N_TOTAL);
      total_err++;
    end
    $display("done: 6 tests, %0d failed, %0d checks, %0d errors", tests_failed, chk_cnt,
             total_err);
    if (total_err == 0) $display("STATUS: PASS");
    else $display("STATUS: FAIL");
    $finish;
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- jedro_exec.f
src/jedro_isa_pkg.sv
src/jedro_core_pkg.sv
src/jedro_decoder.sv
src/jedro_regfile.sv
src/jedro_alu.sv
src/jedro_writeback.sv
src/jedro_exec_top.sv
tests/jedro_exec_asserts.sv
tests/jedro_exec_checker.sv
tests/jedro_exec_tb.sv
